//--- Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module tb_top -f tb.f
	@out=$$(./obj_dir/Vtb_top +verilator+error+limit+1000); echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- source/control_decode.sv
// Opcode decoder turning the I-format instruction into datapath control levels
`timescale 1ns/1ps

module control_decode import mips_pkg::*; (
    input  word_t         instr,
    ctrl_if.driver        ctl
);

    logic [5:0] opcode;

    assign opcode = instr[31:26];

    always_comb begin
        // Defaults give a no-operation
        ctl.reg_we     = 1'b0;
        ctl.alu_op     = alu_add;
        ctl.imm_signed = 1'b1;
        ctl.use_alu    = 1'b1;
        ctl.load_en    = 1'b0;
        ctl.load_ext   = ext_word;
        ctl.store_en   = 1'b0;
        ctl.store_size = size_word;

        case (opcode)
            op_addiu: ctl.reg_we = 1'b1;  // Sign-extended add
            op_andi: begin
                ctl.reg_we     = 1'b1;
                ctl.alu_op     = alu_and;
                ctl.imm_signed = 1'b0;
            end
            op_ori: begin
                ctl.reg_we     = 1'b1;
                ctl.alu_op     = alu_or;
                ctl.imm_signed = 1'b0;
            end
            op_xori: begin
                ctl.reg_we     = 1'b1;
                ctl.alu_op     = alu_xor;
                ctl.imm_signed = 1'b0;
            end
            op_lui: begin
                ctl.reg_we   = 1'b1;
                ctl.use_alu  = 1'b0;      // Immediate goes straight to upper half
                ctl.load_ext = ext_upper;
            end
            // Loads add rs and the signed offset, then shape the DM word
            op_lw, op_lb, op_lbu, op_lh, op_lhu: begin
                ctl.reg_we  = 1'b1;
                ctl.load_en = 1'b1;
                case (opcode)
                    op_lb:   ctl.load_ext = ext_byte_s;
                    op_lbu:  ctl.load_ext = ext_byte_u;
                    op_lh:   ctl.load_ext = ext_half_s;
                    op_lhu:  ctl.load_ext = ext_half_u;
                    default: ctl.load_ext = ext_word;
                endcase
            end
            op_sb: begin
                ctl.store_en   = 1'b1;
                ctl.store_size = size_byte;
            end
            op_sh: begin
                ctl.store_en   = 1'b1;
                ctl.store_size = size_half;
            end
            op_sw: ctl.store_en = 1'b1;
            default: ;  // Unknown opcode writes nothing
        endcase
    end

endmodule

//--- source/ctrl_if.sv
// Decoded control levels passed from the opcode decoder to the datapath units
`timescale 1ns/1ps

interface ctrl_if import mips_pkg::*; ();

    logic    reg_we;      // Register write-back
    alu_op_t alu_op;
    logic    imm_signed;  // Sign extend the immediate
    logic    use_alu;     // Low only for LUI
    logic    load_en;
    ext_t    load_ext;
    logic    store_en;
    size_t   store_size;

    modport driver (
        output reg_we, alu_op, imm_signed, use_alu, load_en, load_ext, store_en, store_size
    );

    modport receiver (
        input reg_we, alu_op, imm_signed, use_alu, load_en, load_ext, store_en, store_size
    );

endinterface

//--- source/exec_unit.sv
// Immediate extension and ALU giving the write-back result or the effective address
`timescale 1ns/1ps

module exec_unit import mips_pkg::*; (
    ctrl_if.receiver   ctl,
    input  word_t      rs_data,
    input  logic [15:0] imm,
    output word_t      result
);

    word_t ext_imm;

    // Sign fill for ADDIU and address offsets, zero fill for logic ops
    assign ext_imm = ctl.imm_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    always_comb begin
        case (ctl.alu_op)
            alu_and: result = rs_data & ext_imm;
            alu_or:  result = rs_data | ext_imm;
            alu_xor: result = rs_data ^ ext_imm;
            default: result = rs_data + ext_imm;  // No overflow trap
        endcase
    end

endmodule

//--- source/load_store_unit.sv
// Store merge into the old DM word and write-back selection with load shaping
`timescale 1ns/1ps

module load_store_unit import mips_pkg::*; (
    ctrl_if.receiver    ctl,
    input  logic [15:0] imm,
    input  word_t       alu_result,
    input  word_t       mem_rdata,
    input  word_t       rt_data,
    output word_t       store_data,
    output word_t       wb_data
);

    word_t shaped;

    // Sub-word stores always hit the low lanes whatever the byte offset
    always_comb begin
        case (ctl.store_size)
            size_byte: store_data = {mem_rdata[31:8], rt_data[7:0]};
            size_half: store_data = {mem_rdata[31:16], rt_data[15:0]};
            default:   store_data = rt_data;
        endcase
    end

    always_comb begin
        case (ctl.load_ext)
            ext_byte_u: shaped = {24'h000000, mem_rdata[7:0]};
            ext_byte_s: shaped = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            ext_half_u: shaped = {16'h0000, mem_rdata[15:0]};
            ext_half_s: shaped = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            ext_upper:  shaped = {imm, 16'h0000};  // LUI value
            default:    shaped = mem_rdata;
        endcase
    end

    // ALU result unless a load or LUI
    assign wb_data = (ctl.load_en || !ctl.use_alu) ? shaped : alu_result;

endmodule

//--- source/mem_port_if.sv
// Word memory port bundle shared by the instruction and data memories of the core
`timescale 1ns/1ps

interface mem_port_if import mips_pkg::*; ();

    mem_idx_t addr;   // Word index
    word_t    wdata;
    logic     we;     // Write at the rising edge
    word_t    rdata;  // Combinational read of addr

    modport master (
        output addr, wdata, we,
        input  rdata
    );

    modport mem (
        input  addr, wdata, we,
        output rdata
    );

endinterface

//--- source/mips_core_top.sv
// Single-cycle MIPS I subset core with debug back door into IM, DM and registers
`timescale 1ns/1ps

module mips_core_top import mips_pkg::*; (
    input  logic        mem_debug_clk_gate,
    input  logic        HW_RSTn,
    input  word_t       din,
    input  word_t       addr,
    output word_t       dout,
    input  logic [1:0]  debug_func,
    input  logic        debug_we,
    input  logic        mem_debug
);

    word_t    pc;
    word_t    instr;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    word_t    store_data;
    word_t    wb_data;
    reg_idx_t rt_sel;      // Shared by second read and write port
    logic     reg_we;

    mem_port_if im_port ();
    mem_port_if dm_port ();
    ctrl_if     ctl ();

    // PC held at reset address while in debug
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= reset_pc;
        end else if (mem_debug) begin
            pc <= reset_pc;
        end else begin
            pc <= pc + pc_step;
        end
    end

    assign instr = im_port.rdata;

    // Debug muxing with core write enables blocked in debug
    assign im_port.addr  = mem_debug ? addr[6:2] : pc[6:2];
    assign im_port.wdata = din;
    assign im_port.we    = mem_debug && debug_we && (debug_func == dbg_im);

    assign dm_port.addr  = mem_debug ? addr[6:2] : alu_result[6:2];
    assign dm_port.wdata = mem_debug ? din : store_data;
    assign dm_port.we    = mem_debug ? (debug_we && (debug_func == dbg_dm)) : ctl.store_en;

    assign rt_sel = mem_debug ? addr[4:0] : instr[20:16];  // rt in I format
    assign reg_we = mem_debug ? (debug_we && (debug_func == dbg_mr)) : ctl.reg_we;

    // Back door read
    always_comb begin
        case (debug_func)
            dbg_im:  dout = im_port.rdata;
            dbg_dm:  dout = dm_port.rdata;
            dbg_mr:  dout = rt_data;
            default: dout = '0;
        endcase
    end

    word_ram instr_mem (.HW_RSTn, .mem_debug_clk_gate, .port(im_port));
    word_ram data_mem  (.HW_RSTn, .mem_debug_clk_gate, .port(dm_port));

    reg_file reg_file_i (
        .HW_RSTn, .mem_debug_clk_gate,
        .rs_idx(instr[25:21]), .rt_idx(rt_sel), .wr_idx(rt_sel),
        .wr_data(mem_debug ? din : wb_data), .we(reg_we),
        .rs_data, .rt_data
    );

    control_decode control_decode_i (.instr, .ctl(ctl));

    exec_unit exec_unit_i (.ctl(ctl), .rs_data, .imm(instr[15:0]), .result(alu_result));

    load_store_unit load_store_unit_i (
        .ctl(ctl), .imm(instr[15:0]), .alu_result, .mem_rdata(dm_port.rdata),
        .rt_data, .store_data, .wb_data
    );

endmodule

//--- source/mips_pkg.sv
// Shared widths, opcodes and control encodings for the single-cycle MIPS core RTL
package mips_pkg;

    localparam int data_w    = 32;      // Data and address width
    localparam int mem_depth = 32;      // Words per memory
    localparam int reg_count = 32;      // General purpose registers

    typedef logic [data_w-1:0] word_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [4:0]        mem_idx_t;  // Address bits 6 to 2

    localparam word_t reset_pc = 32'd0;
    localparam word_t pc_step  = 32'd4;

    // MIPS I primary opcodes
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_andi  = 6'b001100;
    localparam logic [5:0] op_ori   = 6'b001101;
    localparam logic [5:0] op_xori  = 6'b001110;
    localparam logic [5:0] op_lui   = 6'b001111;
    localparam logic [5:0] op_lb    = 6'b100000;
    localparam logic [5:0] op_lh    = 6'b100001;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_lbu   = 6'b100100;
    localparam logic [5:0] op_lhu   = 6'b100101;
    localparam logic [5:0] op_sb    = 6'b101000;
    localparam logic [5:0] op_sh    = 6'b101001;
    localparam logic [5:0] op_sw    = 6'b101011;

    typedef enum logic [1:0] {alu_add, alu_and, alu_or, alu_xor} alu_op_t;

    // Load or immediate shaping of the write-back value
    typedef enum logic [2:0] {
        ext_word, ext_byte_u, ext_byte_s, ext_half_u, ext_half_s, ext_upper
    } ext_t;

    typedef enum logic [1:0] {size_byte, size_half, size_word} size_t;

    // Debug target, as driven on debug_func
    typedef enum logic [1:0] {
        dbg_none = 2'd0, dbg_im = 2'd1, dbg_dm = 2'd2, dbg_mr = 2'd3
    } dbg_sel_t;

endpackage

//--- source/reg_file.sv
// General purpose register file with two combinational reads and one clocked write
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic     HW_RSTn,
    input  logic     mem_debug_clk_gate,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  logic     we,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [reg_count];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != '0)) begin  // r0 is never written
            regs[wr_idx] <= wr_data;
        end
    end

    // r0 hardwired to zero on both read ports
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

//--- source/word_ram.sv
// 32-word memory with combinational read and clocked write for both IM and DM
`timescale 1ns/1ps

module word_ram import mips_pkg::*; (
    input logic HW_RSTn,
    input logic mem_debug_clk_gate,
    mem_port_if.mem port
);

    word_t mem [mem_depth];

    // Whole array cleared on reset
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (port.we) begin
            mem[port.addr] <= port.wdata;  // One-edge write
        end
    end

    // Zero-latency read
    assign port.rdata = mem[port.addr];

endmodule

//--- tb.f
source/mips_pkg.sv
source/mem_port_if.sv
source/ctrl_if.sv
source/word_ram.sv
source/reg_file.sv
source/control_decode.sv
source/exec_unit.sv
source/load_store_unit.sv
source/mips_core_top.sv
test/clk_rst_gen.sv
test/mips_checker.sv
test/tb_top.sv

//--- test/clk_rst_gen.sv
// Free-running 8 ns clock and a two-cycle active-low reset for the core testbench
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;  // Released 1 ns after the second edge
    end

endmodule

//--- test/mips_checker.sv
// Assertions bound into the core top for PC hold, debug write gating and idle dout
`timescale 1ns/1ps

module mips_checker import mips_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       mem_debug,
    input logic       debug_we,
    input logic [1:0] debug_func,
    input word_t      pc,
    input logic       dm_we,
    input word_t      dout
);

    int violations = 0;  // Count of failed assertions

    // Debug forces the PC back to its reset address
    pc_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_debug |=> (pc == reset_pc))
        else begin
            violations = violations + 1;
            $error("PC not at reset address one cycle after debug was high");
        end

    // In debug only the back door may write DM
    dm_we_a: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_debug && dm_we) |-> (debug_we && (debug_func == dbg_dm)))
        else begin
            violations = violations + 1;
            $error("DM write enable high in debug without a DM back door write");
        end

    dout_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        (debug_func == dbg_none) |-> (dout == '0))
        else begin
            violations = violations + 1;
            $error("dout not zero while no debug target is selected");
        end

endmodule

bind mips_core_top mips_checker checker_i (
    .clk(mem_debug_clk_gate), .rst_n(HW_RSTn), .mem_debug, .debug_we, .debug_func,
    .pc, .dm_we(dm_port.we), .dout
);

//--- test/tb_top.sv
// Testbench loading random programs through the debug port and checking state against a model
`timescale 1ns/1ps

module tb_top import mips_pkg::*; ();

    localparam int n_tests   = 7;
    localparam int prog_max  = 32;  // Longest program the IM can hold
    localparam int wd_cycles = n_tests * (64 + 2 * prog_max) + 100;

    logic       clk;
    logic       rst_n;
    word_t      din;
    word_t      addr;
    word_t      dout;
    logic [1:0] debug_func;
    logic       debug_we;
    logic       mem_debug;

    word_t m_reg [32];  // Model registers
    word_t m_dm  [32];  // Model DM
    word_t m_im  [32];
    word_t prog  [32];  // Program under test

    logic [31:0] lfsr = 32'd6;
    logic [5:0]  op_table [16];  // ALU, LUI and loads, stores, unknowns
    int          errors;
    int          test_err;       // Error count when the test started
    int          tests_ok;
    int          tests_bad;

    logic  chk_valid;  // Read request for the compare process
    word_t chk_exp;
    string chk_name;

    clk_rst_gen clk_rst_gen_i (.clk, .rst_n);

    mips_core_top mips_core_top_i (
        .mem_debug_clk_gate(clk), .HW_RSTn(rst_n), .din, .addr, .dout,
        .debug_func, .debug_we, .mem_debug
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Reference model of one instruction on the model state
    function automatic void ref_exec(input word_t ins);
        logic [5:0]  op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
        word_t       ea;
        word_t       w;
        word_t       t;
        word_t       res;
        logic        wr;
        op  = ins[31:26];
        rs  = ins[25:21];
        rt  = ins[20:16];
        imm = ins[15:0];
        ea  = m_reg[rs] + {{16{imm[15]}}, imm};  // Also the ADDIU sum
        w   = m_dm[ea[6:2]];                     // Only bits 6 to 2 pick the word
        t   = m_reg[rt];
        wr  = 1'b1;
        res = '0;
        case (op)
            op_addiu: res = ea;
            op_andi:  res = m_reg[rs] & {16'h0000, imm};
            op_ori:   res = m_reg[rs] | {16'h0000, imm};
            op_xori:  res = m_reg[rs] ^ {16'h0000, imm};
            op_lui:   res = {imm, 16'h0000};
            op_lw:    res = w;
            op_lb:    res = {{24{w[7]}}, w[7:0]};
            op_lbu:   res = {24'h000000, w[7:0]};
            op_lh:    res = {{16{w[15]}}, w[15:0]};
            op_lhu:   res = {16'h0000, w[15:0]};
            op_sb: begin
                wr = 1'b0;
                m_dm[ea[6:2]] = {w[31:8], t[7:0]};  // Low byte lane only
            end
            op_sh: begin
                wr = 1'b0;
                m_dm[ea[6:2]] = {w[31:16], t[15:0]};
            end
            op_sw: begin
                wr = 1'b0;
                m_dm[ea[6:2]] = t;
            end
            default: wr = 1'b0;  // Unknown opcode is a no-op
        endcase
        if (wr && (rt != '0)) begin
            m_reg[rt] = res;
        end
    endfunction

    // Kind 0 ALU, 1 LUI and loads, 2 stores, else all kept opcodes plus unknowns
    function automatic void gen_prog(input int n, input int kind);
        int          idx;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
        for (int i = 0; i < n; i++) begin
            case (kind)
                0:       idx = int'(rnd(2));
                1:       idx = 4 + int'(rnd(3)) % 6;
                2:       idx = 10 + int'(rnd(2)) % 3;
                default: idx = int'(rnd(4));
            endcase
            rs  = reg_idx_t'(int'(rnd(3)) % 7 + 1);  // Base r1 to r7
            rt  = reg_idx_t'(rnd(5));
            imm = 16'(rnd(16));
            prog[i] = {op_table[idx], rs, rt, imm};
        end
    endfunction

    task automatic dbg_write(input dbg_sel_t sel, input word_t a, input word_t d);
        mem_debug  = 1'b1;
        debug_func = sel;
        addr       = a;
        din        = d;
        debug_we   = 1'b1;
        @(posedge clk);
        #1 debug_we = 1'b0;
    endtask

    // Compared at the falling edge by the compare process
    task automatic expect_read(input dbg_sel_t sel, input word_t a, input word_t e,
                               input string nm);
        mem_debug  = 1'b1;
        debug_func = sel;
        addr       = a;
        chk_exp    = e;
        chk_name   = nm;
        chk_valid  = 1'b1;
        @(posedge clk);
        #1 chk_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (chk_valid) begin
            assert (dout === chk_exp)
            else begin
                $display("mismatch at time %0t: dout (%s) expected %08h actual %08h",
                         $time, chk_name, chk_exp, dout);
                errors++;
            end
        end
    end

    task automatic check_state();
        for (int i = 0; i < 32; i++) begin
            expect_read(dbg_mr, word_t'(i), m_reg[i], $sformatf("r%0d", i));
        end
        for (int i = 0; i < 32; i++) begin
            expect_read(dbg_dm, word_t'(i * 4), m_dm[i], $sformatf("dm[%0d]", i));
        end
    endtask

    task automatic preload_regs();
        word_t v;
        for (int i = 1; i < 8; i++) begin
            v = rnd(32);
            m_reg[i] = v;
            dbg_write(dbg_mr, word_t'(i), v);
        end
    endtask

    // Load n words into IM, then run exactly stop cycles out of debug
    task automatic run_prog(input int n, input int stop);
        for (int i = 0; i < n; i++) begin
            dbg_write(dbg_im, word_t'(i * 4), prog[i]);
        end
        for (int i = 0; i < stop; i++) begin
            ref_exec(prog[i]);
        end
        debug_func = dbg_none;
        mem_debug  = 1'b0;     // PC still at 0, first edge runs prog[0]
        repeat (stop) @(posedge clk);
        #1 mem_debug = 1'b1;
    endtask

    task automatic end_test(input string nm);
        if (errors == test_err) begin
            tests_ok++;
            $display("test %s: ok", nm);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d mismatches", nm, errors - test_err);
        end
        test_err = errors;
    endtask

    initial begin
        word_t v;
        op_table = '{op_addiu, op_andi, op_ori, op_xori, op_lui, op_lw, op_lb, op_lbu,
                     op_lh, op_lhu, op_sb, op_sh, op_sw, 6'b000000, 6'b000100, 6'b001010};
        din        = '0;
        addr       = '0;
        debug_func = dbg_none;
        debug_we   = 1'b0;
        mem_debug  = 1'b1;
        chk_valid  = 1'b0;
        chk_exp    = '0;
        errors     = 0;
        test_err   = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        for (int i = 0; i < 32; i++) begin
            m_reg[i] = '0;
            m_dm[i]  = '0;
            m_im[i]  = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;

        for (int i = 0; i < 32; i++) begin
            expect_read(dbg_im, word_t'(i * 4), '0, $sformatf("im[%0d]", i));
        end
        check_state();  // Model is all zero here
        end_test("reset");

        for (int i = 0; i < 32; i++) begin
            m_im[i] = rnd(32);
            dbg_write(dbg_im, word_t'(i * 4), m_im[i]);
            m_dm[i] = rnd(32);
            dbg_write(dbg_dm, word_t'(i * 4), m_dm[i]);
            v = rnd(32);
            if (i != 0) begin
                m_reg[i] = v;  // r0 drops the write
            end
            dbg_write(dbg_mr, word_t'(i), v);
        end
        for (int i = 0; i < 32; i++) begin
            expect_read(dbg_im, word_t'(i * 4), m_im[i], $sformatf("im[%0d]", i));
        end
        check_state();
        end_test("back door");

        preload_regs();
        gen_prog(16, 0);
        run_prog(16, 16);
        check_state();
        end_test("alu imm");

        for (int i = 0; i < 8; i++) begin
            v = rnd(32);
            m_dm[i] = v;
            dbg_write(dbg_dm, word_t'(i * 4), v);
        end
        preload_regs();
        gen_prog(16, 1);
        run_prog(16, 16);
        check_state();
        end_test("lui loads");

        preload_regs();
        gen_prog(16, 2);
        run_prog(16, 16);
        check_state();
        end_test("stores");

        preload_regs();
        gen_prog(20, 3);
        run_prog(20, 20);
        check_state();
        end_test("mixed");

        // Debug raised halfway so later instructions never land
        preload_regs();
        gen_prog(16, 3);
        run_prog(16, 8);
        check_state();
        end_test("debug hold");

        $display("tests passed %0d failed %0d checker violations %0d",
                 tests_ok, tests_bad, mips_core_top_i.checker_i.violations);
        if (tests_bad == 0 && mips_core_top_i.checker_i.violations == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count and the longest program
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", wd_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule
